//--- median_config.svh
`ifndef MEDIAN_CONFIG_SVH
`define MEDIAN_CONFIG_SVH

// bits per pixel
`define MEDIAN_DATA_WIDTH 8

// pair slots in the output buffer, also the upstream credits after reset
`define MEDIAN_FIFO_DEPTH 4

// credits held toward downstream after reset
`define MEDIAN_OUT_CREDITS 2

// register stages inside median_finisher
`define MEDIAN_FINISH_LATENCY 2

`endif

//--- median_pkg.sv
`include "median_config.svh"

package median_pkg;

    // one unsigned pixel
    typedef logic [`MEDIAN_DATA_WIDTH-1:0] pixel_t;

    // buffer fill level, 0 up to MEDIAN_FIFO_DEPTH
    typedef logic [$clog2(`MEDIAN_FIFO_DEPTH + 1)-1:0] slot_count_t;

    // output credit count, 0 up to MEDIAN_OUT_CREDITS
    typedef logic [$clog2(`MEDIAN_OUT_CREDITS + 1)-1:0] credit_count_t;

endpackage

//--- common_network.sv
`timescale 1ns/1ps
`include "median_config.svh"

module common_network
(
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  median_pkg::pixel_t x2_y1,
    input  median_pkg::pixel_t x2_y0,
    input  median_pkg::pixel_t x2_ym1,
    input  median_pkg::pixel_t x1_y1,
    input  median_pkg::pixel_t x1_y0,
    input  median_pkg::pixel_t x1_ym1,
    input  median_pkg::pixel_t x0_y1,
    input  median_pkg::pixel_t x0_y0,
    input  median_pkg::pixel_t x0_ym1,
    input  median_pkg::pixel_t xm1_y1,
    input  median_pkg::pixel_t xm1_y0,
    input  median_pkg::pixel_t xm1_ym1,
    output logic               col_valid,
    output median_pkg::pixel_t c3l,
    output median_pkg::pixel_t c3m,
    output median_pkg::pixel_t c3h,
    output median_pkg::pixel_t c2l,
    output median_pkg::pixel_t c2m,
    output median_pkg::pixel_t c2h,
    output median_pkg::pixel_t c1l,
    output median_pkg::pixel_t c1m,
    output median_pkg::pixel_t c1h,
    output median_pkg::pixel_t c0l,
    output median_pkg::pixel_t c0m,
    output median_pkg::pixel_t c0h
);

    median_pkg::pixel_t row_top [4]; // y = 1
    median_pkg::pixel_t row_mid [4]; // y = 0
    median_pkg::pixel_t row_bot [4]; // y = -1

    median_pkg::pixel_t l1_hi [4];
    median_pkg::pixel_t l1_lo [4];
    median_pkg::pixel_t l2_hi [4];
    median_pkg::pixel_t l2_lo [4];
    median_pkg::pixel_t l3_hi [4];
    median_pkg::pixel_t l3_lo [4];

    median_pkg::pixel_t lo_q [4];
    median_pkg::pixel_t mid_q [4];
    median_pkg::pixel_t hi_q [4];

    // column 3 is x = 2, column 0 is x = -1
    assign row_top[3] = x2_y1;
    assign row_mid[3] = x2_y0;
    assign row_bot[3] = x2_ym1;
    assign row_top[2] = x1_y1;
    assign row_mid[2] = x1_y0;
    assign row_bot[2] = x1_ym1;
    assign row_top[1] = x0_y1;
    assign row_mid[1] = x0_y0;
    assign row_bot[1] = x0_ym1;
    assign row_top[0] = xm1_y1;
    assign row_mid[0] = xm1_y0;
    assign row_bot[0] = xm1_ym1;

    for (genvar col = 0; col < 4; col++)
    begin : g_col
        // sort top and mid rows
        node u_layer1
        (
            .data_a  (row_top[col]),
            .data_b  (row_mid[col]),
            .data_hi (l1_hi[col]),
            .data_lo (l1_lo[col])
        );

        // low of the pair against the bottom row gives the column minimum
        node u_layer2
        (
            .data_a  (l1_lo[col]),
            .data_b  (row_bot[col]),
            .data_hi (l2_hi[col]),
            .data_lo (l2_lo[col])
        );

        // remaining two sorted into mid and high
        node u_layer3
        (
            .data_a  (l1_hi[col]),
            .data_b  (l2_hi[col]),
            .data_hi (l3_hi[col]),
            .data_lo (l3_lo[col])
        );

        always_ff @(posedge clk)
        begin
            if (in_valid)
            begin
                lo_q[col]  <= l2_lo[col];
                mid_q[col] <= l3_lo[col];
                hi_q[col]  <= l3_hi[col];
            end
        end

        a_col_sorted: assert property (@(posedge clk) disable iff (rst)
            col_valid |-> (lo_q[col] <= mid_q[col] && mid_q[col] <= hi_q[col]));
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            col_valid <= 1'b0;
        else
            col_valid <= in_valid; // data regs load on the same edge
    end

    assign c3l = lo_q[3];
    assign c3m = mid_q[3];
    assign c3h = hi_q[3];
    assign c2l = lo_q[2];
    assign c2m = mid_q[2];
    assign c2h = hi_q[2];
    assign c1l = lo_q[1];
    assign c1m = mid_q[1];
    assign c1h = hi_q[1];
    assign c0l = lo_q[0];
    assign c0m = mid_q[0];
    assign c0h = hi_q[0];

endmodule

module node
(
    input  median_pkg::pixel_t data_a,
    input  median_pkg::pixel_t data_b,
    output median_pkg::pixel_t data_hi,
    output median_pkg::pixel_t data_lo
);

    logic a_lower;

    always_comb
    begin
        a_lower = (data_a < data_b); // strict, so a tie sends data_b low
        if (a_lower)
        begin
            data_lo = data_a;
            data_hi = data_b;
        end
        else
        begin
            data_lo = data_b;
            data_hi = data_a;
        end
    end

endmodule

//--- median_finisher.sv
`timescale 1ns/1ps
`include "median_config.svh"

module median_finisher
(
    input  logic               clk,
    input  median_pkg::pixel_t hi_a,
    input  median_pkg::pixel_t hi_b,
    input  median_pkg::pixel_t hi_c,
    input  median_pkg::pixel_t mid_a,
    input  median_pkg::pixel_t mid_b,
    input  median_pkg::pixel_t mid_c,
    input  median_pkg::pixel_t lo_a,
    input  median_pkg::pixel_t lo_b,
    input  median_pkg::pixel_t lo_c,
    output median_pkg::pixel_t med
);

    median_pkg::pixel_t max_lo_q;
    median_pkg::pixel_t med_mid_q;
    median_pkg::pixel_t min_hi_q;

    function automatic median_pkg::pixel_t max3(input median_pkg::pixel_t a,
                                                input median_pkg::pixel_t b,
                                                input median_pkg::pixel_t c);
        median_pkg::pixel_t ab;
        ab = (a > b) ? a : b;
        return (ab > c) ? ab : c;
    endfunction

    function automatic median_pkg::pixel_t min3(input median_pkg::pixel_t a,
                                                input median_pkg::pixel_t b,
                                                input median_pkg::pixel_t c);
        median_pkg::pixel_t ab;
        ab = (a < b) ? a : b;
        return (ab < c) ? ab : c;
    endfunction

    // clamp c into the range spanned by a and b
    function automatic median_pkg::pixel_t med3(input median_pkg::pixel_t a,
                                                input median_pkg::pixel_t b,
                                                input median_pkg::pixel_t c);
        median_pkg::pixel_t lo_ab;
        median_pkg::pixel_t hi_ab;
        lo_ab = (a < b) ? a : b;
        hi_ab = (a < b) ? b : a;
        return (c < lo_ab) ? lo_ab : ((c > hi_ab) ? hi_ab : c);
    endfunction

    always_ff @(posedge clk)
    begin
        max_lo_q  <= max3(lo_a, lo_b, lo_c);    // stage one
        med_mid_q <= med3(mid_a, mid_b, mid_c);
        min_hi_q  <= min3(hi_a, hi_b, hi_c);
        med       <= med3(max_lo_q, med_mid_q, min_hi_q); // median of nine
    end

    // a swapped lo/hi hookup at the top shows up as unsorted columns here
    a_cols_sorted: assert property (@(posedge clk)
        !$isunknown({lo_a, lo_b, lo_c, mid_a, mid_b, mid_c, hi_a, hi_b, hi_c}) |->
        (lo_a <= mid_a && mid_a <= hi_a &&
         lo_b <= mid_b && mid_b <= hi_b &&
         lo_c <= mid_c && mid_c <= hi_c));

endmodule

//--- pixel_pair_buffer.sv
`timescale 1ns/1ps
`include "median_config.svh"

module pixel_pair_buffer
(
    input  logic               clk,
    input  logic               rst,
    input  logic               col_valid,
    input  median_pkg::pixel_t med_x0,
    input  median_pkg::pixel_t med_x1,
    input  logic               out_credit,
    output logic               out_valid,
    output logic               in_credit,
    output median_pkg::pixel_t out_pix0,
    output median_pkg::pixel_t out_pix1
);

    localparam int DEPTH = `MEDIAN_FIFO_DEPTH;
    localparam int LAT   = `MEDIAN_FINISH_LATENCY;
    localparam int PTR_W = $clog2(DEPTH);
    localparam median_pkg::slot_count_t   FULL_LEVEL   = `MEDIAN_FIFO_DEPTH;
    localparam median_pkg::credit_count_t CREDITS_INIT = `MEDIAN_OUT_CREDITS;

    logic [LAT-1:0] vld_pipe; // col_valid aligned with the finisher output
    logic           wr_en;
    logic           pop;

    median_pkg::pixel_t mem_pix0 [DEPTH];
    median_pkg::pixel_t mem_pix1 [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    median_pkg::slot_count_t   fill;
    median_pkg::credit_count_t credits;

    always_ff @(posedge clk)
    begin
        if (rst)
            vld_pipe <= '0;
        else
        begin
            vld_pipe[0] <= col_valid;
            for (int i = 1; i < LAT; i++)
                vld_pipe[i] <= vld_pipe[i-1];
        end
    end

    assign wr_en = vld_pipe[LAT-1];
    assign pop   = (fill != '0) && (credits != '0);

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem_pix0[wr_ptr] <= med_x0; // both medians land in one slot
            mem_pix1[wr_ptr] <= med_x1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr_en, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            credits <= CREDITS_INIT;
        else // consume and return may coincide
            credits <= credits - median_pkg::credit_count_t'(pop)
                               + median_pkg::credit_count_t'(out_credit);
    end

    assign out_valid = pop;
    assign in_credit = pop; // slot freed, upstream gets a credit back
    assign out_pix0  = mem_pix0[rd_ptr];
    assign out_pix1  = mem_pix1[rd_ptr];

    // upstream credits bound everything in flight to the FIFO size
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> (fill != FULL_LEVEL));

    // downstream never returns more than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= CREDITS_INIT);

endmodule

//--- median2_top.sv
`timescale 1ns/1ps
`include "median_config.svh"

module median2_top
(
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  median_pkg::pixel_t x2_y1,
    input  median_pkg::pixel_t x2_y0,
    input  median_pkg::pixel_t x2_ym1,
    input  median_pkg::pixel_t x1_y1,
    input  median_pkg::pixel_t x1_y0,
    input  median_pkg::pixel_t x1_ym1,
    input  median_pkg::pixel_t x0_y1,
    input  median_pkg::pixel_t x0_y0,
    input  median_pkg::pixel_t x0_ym1,
    input  median_pkg::pixel_t xm1_y1,
    input  median_pkg::pixel_t xm1_y0,
    input  median_pkg::pixel_t xm1_ym1,
    output logic               in_credit,
    output logic               out_valid,
    output median_pkg::pixel_t out_pix0,
    output median_pkg::pixel_t out_pix1,
    input  logic               out_credit
);

    logic               col_valid;
    median_pkg::pixel_t c3l, c3m, c3h;
    median_pkg::pixel_t c2l, c2m, c2h;
    median_pkg::pixel_t c1l, c1m, c1h;
    median_pkg::pixel_t c0l, c0m, c0h;
    median_pkg::pixel_t med_x0;
    median_pkg::pixel_t med_x1;

    common_network u_net
    (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .x2_y1     (x2_y1),
        .x2_y0     (x2_y0),
        .x2_ym1    (x2_ym1),
        .x1_y1     (x1_y1),
        .x1_y0     (x1_y0),
        .x1_ym1    (x1_ym1),
        .x0_y1     (x0_y1),
        .x0_y0     (x0_y0),
        .x0_ym1    (x0_ym1),
        .xm1_y1    (xm1_y1),
        .xm1_y0    (xm1_y0),
        .xm1_ym1   (xm1_ym1),
        .col_valid (col_valid),
        .c3l (c3l), .c3m (c3m), .c3h (c3h),
        .c2l (c2l), .c2m (c2m), .c2h (c2h),
        .c1l (c1l), .c1m (c1m), .c1h (c1h),
        .c0l (c0l), .c0m (c0m), .c0h (c0h)
    );

    // pixel at x = 1, columns x = 0..2
    median_finisher u_fin_x1
    (
        .clk   (clk),
        .hi_a  (c3h), .hi_b  (c2h), .hi_c  (c1h),
        .mid_a (c3m), .mid_b (c2m), .mid_c (c1m),
        .lo_a  (c3l), .lo_b  (c2l), .lo_c  (c1l),
        .med   (med_x1)
    );

    // pixel at x = 0, columns x = -1..1
    median_finisher u_fin_x0
    (
        .clk   (clk),
        .hi_a  (c2h), .hi_b  (c1h), .hi_c  (c0h),
        .mid_a (c2m), .mid_b (c1m), .mid_c (c0m),
        .lo_a  (c2l), .lo_b  (c1l), .lo_c  (c0l),
        .med   (med_x0)
    );

    pixel_pair_buffer u_buf
    (
        .clk        (clk),
        .rst        (rst),
        .col_valid  (col_valid),
        .med_x0     (med_x0),
        .med_x1     (med_x1),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .in_credit  (in_credit),
        .out_pix0   (out_pix0),
        .out_pix1   (out_pix1)
    );

endmodule

//--- tb_median2.sv
`timescale 1ns/1ps
`include "median_config.svh"

module tb_median2;

    localparam int W              = `MEDIAN_DATA_WIDTH;
    localparam int DEPTH          = `MEDIAN_FIFO_DEPTH;
    localparam int OUT_CRED       = `MEDIAN_OUT_CREDITS;
    localparam int NUM_BEATS      = 84;
    localparam int TIMEOUT_CYCLES = NUM_BEATS * 20 + 2000;

    // column-major patch with col 0 at x = -1 and row 0 at y = -1
    typedef logic [12*W-1:0] patch_t;

    logic clk        = 1'b0;
    logic rst        = 1'b1;
    logic in_valid   = 1'b0;
    logic out_credit = 1'b0;
    median_pkg::pixel_t x2_y1 = '0, x2_y0 = '0, x2_ym1 = '0;
    median_pkg::pixel_t x1_y1 = '0, x1_y0 = '0, x1_ym1 = '0;
    median_pkg::pixel_t x0_y1 = '0, x0_y0 = '0, x0_ym1 = '0;
    median_pkg::pixel_t xm1_y1 = '0, xm1_y0 = '0, xm1_ym1 = '0;
    logic               in_credit;
    logic               out_valid;
    median_pkg::pixel_t out_pix0;
    median_pkg::pixel_t out_pix1;

    logic [31:0] lfsr = 32'h9654f268;
    int   cycle;
    int   up_credits = DEPTH; // credits held by the upstream driver
    int   in_credit_total;
    int   delivered_total;
    int   pairs_in_test;
    int   beats_sent;
    int   first_out_cycle;
    int   last_out_cycle;
    int   last_send_cycle;
    int   credit_delay; // sink hold-off in cycles
    logic hold_credits = 1'b0;
    int   value_errors;
    int   protocol_errors;

    patch_t             beat_q [$];
    median_pkg::pixel_t exp0_q [$];
    median_pkg::pixel_t exp1_q [$];
    int                 due_q [$]; // cycles at which the sink returns a credit

    median2_top u_median2_top
    (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .x2_y1      (x2_y1),
        .x2_y0      (x2_y0),
        .x2_ym1     (x2_ym1),
        .x1_y1      (x1_y1),
        .x1_y0      (x1_y0),
        .x1_ym1     (x1_ym1),
        .x0_y1      (x0_y1),
        .x0_y0      (x0_y0),
        .x0_ym1     (x0_ym1),
        .xm1_y1     (xm1_y1),
        .xm1_y0     (xm1_y0),
        .xm1_ym1    (xm1_ym1),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_pix0   (out_pix0),
        .out_pix1   (out_pix1),
        .out_credit (out_credit)
    );

    initial
    begin
        forever #5 clk = ~clk;
    end

    task automatic check_pixel(input string name, input median_pkg::pixel_t actual,
                               input median_pkg::pixel_t expected);
        if (actual !== expected)
        begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_count(input string name, input median_pkg::slot_count_t actual,
                               input median_pkg::slot_count_t expected);
        if (actual !== expected)
        begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_number(input string name, input int actual, input int expected);
        if (actual != expected)
        begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic median_pkg::pixel_t rand_pixel();
        median_pkg::pixel_t p;
        for (int i = 0; i < W; i++)
            p[i] = lfsr_bit();
        return p;
    endfunction

    function automatic median_pkg::pixel_t pix_at(input patch_t p, input int col, input int row);
        return p[(col * 3 + row) * W +: W];
    endfunction

    // reference model sorts the nine pixels of a 3x3 window and takes the fifth
    function automatic median_pkg::pixel_t window_median(input patch_t p, input int first_col);
        median_pkg::pixel_t w [9];
        median_pkg::pixel_t t;
        int                 k;
        for (int c = 0; c < 3; c++)
            for (int r = 0; r < 3; r++)
                w[c * 3 + r] = pix_at(p, first_col + c, r);
        for (int i = 1; i < 9; i++)
        begin
            t = w[i];
            k = i - 1;
            while (k >= 0 && w[k] > t)
            begin
                w[k + 1] = w[k];
                k--;
            end
            w[k + 1] = t;
        end
        return w[4];
    endfunction

    task automatic set_column(inout patch_t p, input int col, input int ym1, input int y0,
                              input int y1);
        p[(col * 3 + 0) * W +: W] = median_pkg::pixel_t'(ym1);
        p[(col * 3 + 1) * W +: W] = median_pkg::pixel_t'(y0);
        p[(col * 3 + 2) * W +: W] = median_pkg::pixel_t'(y1);
    endtask

    task automatic queue_beat(input patch_t p);
        beat_q.push_back(p);
        exp0_q.push_back(window_median(p, 0)); // x = 0 uses columns -1..1
        exp1_q.push_back(window_median(p, 1)); // x = 1 uses columns 0..2
    endtask

    task automatic queue_random_beats(input int n);
        patch_t p;
        repeat (n)
        begin
            for (int i = 0; i < 12; i++)
                p[i * W +: W] = rand_pixel();
            queue_beat(p);
        end
    endtask

    task automatic apply_patch(input patch_t p);
        xm1_ym1 = pix_at(p, 0, 0);
        xm1_y0  = pix_at(p, 0, 1);
        xm1_y1  = pix_at(p, 0, 2);
        x0_ym1  = pix_at(p, 1, 0);
        x0_y0   = pix_at(p, 1, 1);
        x0_y1   = pix_at(p, 1, 2);
        x1_ym1  = pix_at(p, 2, 0);
        x1_y0   = pix_at(p, 2, 1);
        x1_y1   = pix_at(p, 2, 2);
        x2_ym1  = pix_at(p, 3, 0);
        x2_y0   = pix_at(p, 3, 1);
        x2_y1   = pix_at(p, 3, 2);
    endtask

    task automatic collect_pair();
        if (in_credit)
        begin
            up_credits++;
            in_credit_total++;
        end
        if (in_credit !== out_valid)
        begin
            protocol_errors++;
            $display("%0t: in_credit pulse not aligned with out_valid", $time);
        end
        if (up_credits > DEPTH)
        begin
            protocol_errors++;
            $display("%0t: upstream got back more credits than buffer slots", $time);
        end
        if (out_valid)
        begin
            if (exp0_q.size() == 0)
            begin
                protocol_errors++;
                $display("%0t: output pair arrived with none expected", $time);
            end
            else
            begin
                check_pixel("out_pix0", out_pix0, exp0_q.pop_front());
                check_pixel("out_pix1", out_pix1, exp1_q.pop_front());
            end
            delivered_total++;
            pairs_in_test++;
            if (first_out_cycle < 0)
                first_out_cycle = cycle;
            last_out_cycle = cycle;
            due_q.push_back(cycle + credit_delay);
        end
    endtask

    task automatic return_credit();
        if (!hold_credits && due_q.size() > 0 && due_q[0] <= cycle)
        begin
            out_credit = 1'b1;
            due_q.delete(0);
        end
        else
            out_credit = 1'b0;
    endtask

    task automatic drive_beat();
        if (beat_q.size() > 0 && up_credits > 0)
        begin
            apply_patch(beat_q.pop_front());
            in_valid = 1'b1;
            up_credits--;
            beats_sent++;
            last_send_cycle = cycle;
        end
        else
            in_valid = 1'b0;
    endtask

    // monitor first so a returned credit is spent in the same cycle
    always @(negedge clk)
    begin
        cycle++;
        collect_pair();
        return_credit();
        drive_beat();
    end

    task automatic start_test(input string name);
        $display("%0t: %s", $time, name);
        pairs_in_test   = 0;
        beats_sent      = 0;
        first_out_cycle = -1;
    endtask

    task automatic wait_idle();
        while (beat_q.size() > 0 || exp0_q.size() > 0 || due_q.size() > 0)
            @(posedge clk);
    endtask

    task automatic test_single_beat();
        start_test("single beat latency");
        queue_random_beats(1);
        wait_idle();
        check_number("pairs", pairs_in_test, 1);
        check_number("latency", last_out_cycle - last_send_cycle, 4);
    endtask

    task automatic test_full_rate(input int n);
        start_test("full rate stream");
        credit_delay = 0;
        queue_random_beats(n);
        wait_idle();
        check_number("pairs", pairs_in_test, n);
        check_number("stream span", last_out_cycle - first_out_cycle + 1, n);
    endtask

    task automatic test_back_pressure(input int n);
        start_test("back-pressure");
        hold_credits = 1'b1;
        queue_random_beats(n);
        repeat (40) @(posedge clk); // let the core stall
        check_number("pairs while held", pairs_in_test, OUT_CRED);
        check_number("beats sent while held", beats_sent, DEPTH + OUT_CRED);
        check_count("upstream credits", median_pkg::slot_count_t'(up_credits), '0);
        hold_credits = 1'b0;
        wait_idle();
        check_number("pairs after release", pairs_in_test, n);
    endtask

    task automatic test_credit_balance(input int n);
        start_test("credit balance with sink hold-off");
        credit_delay = 3;
        queue_random_beats(n);
        wait_idle();
        credit_delay = 0;
        check_number("in_credit pulses", in_credit_total, delivered_total);
        check_count("upstream credits", median_pkg::slot_count_t'(up_credits),
                    median_pkg::slot_count_t'(DEPTH));
    endtask

    task automatic test_edge_patterns();
        patch_t p;
        start_test("edge patterns");
        for (int v = 0; v < 3; v++)
            queue_beat({12{median_pkg::pixel_t'(v * 100 + 27)}});
        repeat (4)
        begin
            for (int i = 0; i < 12; i++)
                p[i * W +: W] = {W{lfsr_bit()}}; // only 0 or all ones
            queue_beat(p);
        end
        repeat (4)
        begin
            for (int i = 0; i < 12; i++)
                p[i * W +: W] = lfsr_bit() ? median_pkg::pixel_t'(20) : median_pkg::pixel_t'(10);
            queue_beat(p);
        end
        // outer columns pull the two medians apart
        set_column(p, 0, 0, 0, 0);
        set_column(p, 1, 100, 200, 100);
        set_column(p, 2, 200, 100, 200);
        set_column(p, 3, 255, 255, 255);
        queue_beat(p);
        set_column(p, 0, 255, 255, 255);
        set_column(p, 3, 0, 0, 0);
        queue_beat(p);
        wait_idle();
        check_number("pairs", pairs_in_test, 13);
    endtask

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, %0d pairs never arrived", TIMEOUT_CYCLES,
                 exp0_q.size());
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        repeat (8)
        begin
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("in_credit", in_credit, 1'b0);
        end
        rst = 1'b0;
        @(negedge clk);
        check_flag("out_valid", out_valid, 1'b0); // first cycle out of reset
        check_flag("in_credit", in_credit, 1'b0);
        @(posedge clk);
        test_single_beat();
        test_full_rate(40);
        test_back_pressure(10);
        test_credit_balance(20);
        test_edge_patterns();
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
median_pkg.sv
common_network.sv
median_finisher.sv
pixel_pair_buffer.sv
median2_top.sv
tb_median2.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_median2 -o tb_median2_sim

./obj_dir/tb_median2_sim | tee sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
